// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= test passed

SRCS := $(shell grep -v '^+' $(FILELIST)) rtl/dcache_params.svh
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the output goes to the terminal and is searched for the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== project.f ====
+incdir+rtl
rtl/cpu_pkg.sv
rtl/line_pkg.sv
rtl/ram_tag.sv
rtl/ram_bank.sv
rtl/dcache_way.sv
rtl/dcache.sv
testbench/dcache_tb.sv

// ==== rtl/cpu_pkg.sv ====
`include "dcache_params.svh"

package cpu_pkg;

    // lookup view of an address
    typedef struct packed {
        logic [`DC_TAG_W-1:0]   tag;
        logic [`DC_INDEX_W-1:0] index;
        logic [1:0]             word;   // word within line
        logic [1:0]             boff;   // byte offset, unused by lookup
    } dc_addr_fields_t;

    // raw view goes on the bus, field view drives the lookup
    typedef union packed {
        logic [31:0]     raw;
        dc_addr_fields_t f;
    } dc_addr_u;

    typedef struct packed {
        logic        op;     // 1 = store
        dc_addr_u    addr;
        logic [31:0] wdata;
    } cpu_req_t;

endpackage

// ==== rtl/dcache.sv ====
`timescale 1ns/100ps
`include "dcache_params.svh"

module dcache
    import cpu_pkg::*;
    import line_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,

    input  logic        valid,
    input  cpu_req_t    req,
    output logic        addr_ok,
    output logic        data_ok,
    output logic [31:0] rdata,

    output logic        rd_req,
    output logic [31:0] rd_addr,
    input  logic        rd_rdy,
    input  logic        ret_valid,
    input  line_t       ret_data,

    output logic        wr_req,
    output wb_req_t     wr,
    input  logic        wr_rdy
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REPLACE,
        REFILL
    } state_t;

    state_t state;
    state_t state_nx;

    cpu_req_t                          rq;          // request in flight
    logic [`DC_SETS-1:0]               lru;         // last used way per set
    logic [`DC_INDEX_W-1:0]            ram_index;

    logic [`DC_WAYS-1:0]               hit;
    line_t                             way_line [`DC_WAYS];
    tag_entry_t                        way_entry [`DC_WAYS];
    logic [`DC_WAYS-1:0]               way_dirty;

    logic [`DC_WAYS-1:0]               tag_we;
    logic [`DC_WAYS-1:0]               dirty_we;
    logic [`DC_WAYS-1:0][`DC_WORDS-1:0] word_we;
    tag_entry_t                        wtag;
    line_t                             hit_line;
    line_t                             base_line;
    line_t                             wline;

    logic                              any_hit;
    logic                              store_hit;
    logic                              refill;
    logic                              victim;
    logic                              victim_q;
    logic                              victim_dirty;

    // ram reads use the incoming index at the accept edge
    assign ram_index = (state == IDLE) ? req.addr.f.index : rq.addr.f.index;

    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        dcache_way u_way (
            .clk        (clk),
            .resetn     (resetn),
            .index      (ram_index),
            .lookup_tag (rq.addr.f.tag),
            .tag_we     (tag_we[w]),
            .wtag       (wtag),
            .word_we    (word_we[w]),
            .wline      (wline),
            .dirty_we   (dirty_we[w]),
            .dirty_val  (rq.op),       // stores leave the line dirty
            .line       (way_line[w]),
            .entry      (way_entry[w]),
            .dirty      (way_dirty[w]),
            .hit        (hit[w])
        );
    end

    assign any_hit   = |hit;
    assign store_hit = (state == LOOKUP) && any_hit && rq.op;
    assign refill    = (state == REFILL) && ret_valid;

    assign addr_ok = (state == IDLE);
    assign data_ok = ((state == LOOKUP) && any_hit) || refill;

    always_ff @(posedge clk or posedge resetn) begin
        if (resetn)
            state <= IDLE;
        else
            state <= state_nx;
    end

    always_comb begin
        state_nx = state;
        case (state)
            IDLE:    if (valid) state_nx = LOOKUP;
            LOOKUP:  state_nx = any_hit ? IDLE : MISS;
            MISS:    if (!victim_dirty || wr_rdy) state_nx = REPLACE;
            REPLACE: if (rd_rdy) state_nx = REFILL;
            REFILL:  if (ret_valid) state_nx = IDLE;
            default: state_nx = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (valid && addr_ok)
            rq <= req;
    end

    // invalid way first, then the one not used last
    always_comb begin
        if (!way_entry[0].valid)
            victim = 1'b0;
        else if (!way_entry[1].valid)
            victim = 1'b1;
        else
            victim = !lru[rq.addr.f.index];
    end

    always_ff @(posedge clk or posedge resetn) begin
        if (resetn) begin
            victim_q     <= 1'b0;
            victim_dirty <= 1'b0;
            lru          <= '0;
        end else begin
            if (state == LOOKUP && !any_hit) begin
                victim_q     <= victim;
                victim_dirty <= way_dirty[victim];
            end
            if (state == LOOKUP && any_hit)
                lru[rq.addr.f.index] <= hit[1];
            else if (refill)
                lru[rq.addr.f.index] <= victim_q;
        end
    end

    // write-back payload, captured before the refill overwrites the way
    always_ff @(posedge clk) begin
        if (state == LOOKUP && !any_hit) begin
            wr.addr <= {way_entry[victim].tag, rq.addr.f.index, {`DC_OFFSET_W{1'b0}}};
            wr.data <= way_line[victim];
        end
    end

    assign wr_req  = (state == MISS) && victim_dirty;
    assign rd_req  = (state == REPLACE);
    assign rd_addr = {rq.addr.raw[31:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};

    assign hit_line  = hit[1] ? way_line[1] : way_line[0];
    assign base_line = (state == REFILL) ? ret_data : hit_line;
    assign rdata     = base_line[rq.addr.f.word];
    assign wtag      = '{valid: 1'b1, tag: rq.addr.f.tag};

    always_comb begin
        wline = base_line;
        if (rq.op)
            wline[rq.addr.f.word] = rq.wdata;   // store merge
    end

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            word_we[w]  = '0;
            tag_we[w]   = refill && (victim_q == w[0]);
            if (store_hit && hit[w])
                word_we[w][rq.addr.f.word] = 1'b1;
            else if (tag_we[w])
                word_we[w] = '1;    // whole line on refill
            dirty_we[w] = (store_hit && hit[w]) || tag_we[w];
        end
    end

    // a tag lives in at most one way of a set
    a_hit_onehot: assert property (@(posedge clk) disable iff (resetn)
        (state == LOOKUP) |-> !(hit[0] && hit[1]));

    a_wr_hold: assert property (@(posedge clk) disable iff (resetn)
        (wr_req && !wr_rdy) |=> (state == MISS) && wr_req && $stable(wr));

    a_rd_hold: assert property (@(posedge clk) disable iff (resetn)
        (rd_req && !rd_rdy) |=> (state == REPLACE) && rd_req && $stable(rd_addr));

    // each completion ends the request and frees the cache
    a_done_idle: assert property (@(posedge clk) disable iff (resetn)
        data_ok |-> (state != IDLE) ##1 (state == IDLE));

endmodule

// ==== rtl/dcache_params.svh ====
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// address split, tag | index | offset
`define DC_TAG_W     20
`define DC_INDEX_W   8
`define DC_OFFSET_W  4

`define DC_WAYS      2
`define DC_SETS      256
`define DC_WORDS     4          // 32-bit words per line
`define DC_LINE_W    128

`endif

// ==== rtl/dcache_way.sv ====
`timescale 1ns/100ps
`include "dcache_params.svh"

module dcache_way
    import line_pkg::*;
(
    input  logic                   clk,
    input  logic                   resetn,
    input  logic [`DC_INDEX_W-1:0] index,
    input  logic [`DC_TAG_W-1:0]   lookup_tag,
    input  logic                   tag_we,
    input  tag_entry_t             wtag,
    input  logic [`DC_WORDS-1:0]   word_we,
    input  line_t                  wline,
    input  logic                   dirty_we,
    input  logic                   dirty_val,
    output line_t                  line,
    output tag_entry_t             entry,
    output logic                   dirty,
    output logic                   hit
);

    tag_entry_t          ram_entry;
    logic [`DC_SETS-1:0] valid_r;     // tag ram contents are garbage until written
    logic                valid_q;
    logic [`DC_SETS-1:0] dirty_r;

    ram_tag u_tag (
        .clk   (clk),
        .we    (tag_we),
        .addr  (index),
        .wdata (wtag),
        .rdata (ram_entry)
    );

    for (genvar i = 0; i < `DC_WORDS; i++) begin : g_bank
        ram_bank u_bank (
            .clk   (clk),
            .we    (word_we[i]),
            .addr  (index),
            .wdata (wline[i]),
            .rdata (line[i])
        );
    end

    always_ff @(posedge clk or posedge resetn) begin
        if (resetn) begin
            valid_r <= '0;
            valid_q <= 1'b0;
            dirty_r <= '0;
        end else begin
            if (tag_we)
                valid_r[index] <= wtag.valid;
            valid_q <= tag_we ? wtag.valid : valid_r[index];   // tracks ram read timing
            if (dirty_we)
                dirty_r[index] <= dirty_val;
        end
    end

    assign entry = '{valid: ram_entry.valid & valid_q, tag: ram_entry.tag};
    assign dirty = dirty_r[index];
    assign hit   = entry.valid && (entry.tag == lookup_tag);

    // writes land on the set that was read the cycle before
    a_wr_index_stable: assert property (@(posedge clk) disable iff (resetn)
        (tag_we || |word_we) |-> $stable(index));

endmodule

// ==== rtl/line_pkg.sv ====
`include "dcache_params.svh"

package line_pkg;

    // word 0 sits in the low bits
    typedef logic [`DC_WORDS-1:0][`DC_LINE_W/`DC_WORDS-1:0] line_t;

    typedef struct packed {
        logic                 valid;
        logic [`DC_TAG_W-1:0] tag;
    } tag_entry_t;

    // write-back payload, addr has its offset cleared
    typedef struct packed {
        logic [31:0] addr;
        line_t       data;
    } wb_req_t;

endpackage

// ==== rtl/ram_bank.sv ====
`timescale 1ns/100ps
`include "dcache_params.svh"

module ram_bank (
    input  logic                   clk,
    input  logic                   we,
    input  logic [`DC_INDEX_W-1:0] addr,
    input  logic [31:0]            wdata,
    output logic [31:0]            rdata
);

    logic [31:0] mem [`DC_SETS];

    always_ff @(posedge clk) begin
        if (we)
            mem[addr] <= wdata;
        rdata <= mem[addr];    // read-first
    end

endmodule

// ==== rtl/ram_tag.sv ====
`timescale 1ns/100ps
`include "dcache_params.svh"

module ram_tag
    import line_pkg::*;
(
    input  logic                   clk,
    input  logic                   we,
    input  logic [`DC_INDEX_W-1:0] addr,
    input  tag_entry_t             wdata,
    output tag_entry_t             rdata
);

    tag_entry_t mem [`DC_SETS];

    // write-first, a write shows up on rdata next cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
            rdata     <= wdata;
        end else begin
            rdata <= mem[addr];
        end
    end

endmodule

// ==== testbench/dcache_tb.sv ====
`timescale 1ns/100ps
`include "dcache_params.svh"

module dcache_tb
    import cpu_pkg::*;
    import line_pkg::*;
();

    localparam int N_FIRST = 4;
    localparam int N_LOADS = 60;
    localparam int N_LRU   = 6;
    localparam int N_MIXED = 300;
    localparam int N_REQ   = N_FIRST + N_LOADS + N_LRU + N_MIXED;
    localparam int CLK_NS  = 4;

    logic        clk;
    logic        resetn;
    logic        valid;
    cpu_req_t    req;
    logic        addr_ok;
    logic        data_ok;
    logic [31:0] rdata;
    logic        rd_req;
    logic [31:0] rd_addr;
    logic        rd_rdy;
    logic        ret_valid;
    line_t       ret_data;
    logic        wr_req;
    wb_req_t     wr;
    logic        wr_rdy;

    logic [31:0] lfsr_state;
    logic [31:0] mem  [logic [31:0]];   // backing memory by word address
    logic [31:0] arch [logic [31:0]];   // latest stored values by word address

    // model of tags, dirty and lru per set
    logic                 m_valid [`DC_SETS][2];
    logic [`DC_TAG_W-1:0] m_tag   [`DC_SETS][2];
    logic                 m_dirty [`DC_SETS][2];
    logic                 m_lru   [`DC_SETS];

    int          value_errors;
    int          protocol_errors;
    int          accept_count;
    int          done_count;
    int          rd_count;
    int          wr_count;
    int          rd_stretch;
    int          wr_stretch;
    int          ret_wait;
    int          rd_mark;
    logic [31:0] ret_addr;

    dcache dut (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .req       (req),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr        (wr),
        .wr_rdy    (wr_rdy)
    );

    always #(CLK_NS / 2) clk = ~clk;

    function automatic logic rand_bit();
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
        return lfsr_state[0];
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], rand_bit()};
        return v;
    endfunction

    // odd multiplier so every address bit changes the word
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e3779b1) ^ 32'h5bd1e995;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return mem.exists(a) ? mem[a] : fill_word(a);
    endfunction

    function automatic logic [31:0] arch_word(input logic [31:0] a);
        return arch.exists(a) ? arch[a] : fill_word(a);
    endfunction

    function automatic logic [31:0] mk_addr(input logic [1:0] t, input logic [7:0] idx,
                                            input logic [1:0] w);
        dc_addr_u a;
        a.f.tag   = {t, 18'h0e6b5};
        a.f.index = idx;
        a.f.word  = w;
        a.f.boff  = 2'b00;
        return a.raw;
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, got %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_line(input string name, input line_t exp, input line_t act);
        if (act !== exp) begin
            $display("FAILED %s: expected %h, got %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_addr(input string name, input dc_addr_u exp, input dc_addr_u act);
        if (act.raw !== exp.raw) begin
            $display("FAILED %s: expected %h, got %h", name, exp.raw, act.raw);
            value_errors++;
        end
    endtask

    task automatic protocol_error(input string what);
        $display("%0t ns: %s", $time, what);
        protocol_errors++;
    endtask

    // one request from issue to data_ok against the model
    task automatic run_request(input logic op, input logic [31:0] addr, input logic [31:0] wdata);
        dc_addr_u               a;
        dc_addr_u               line_a;
        dc_addr_u               wb_a;
        line_t                  wb_line;
        cpu_req_t               r;
        logic [`DC_INDEX_W-1:0] idx;
        logic [31:0]            exp_rd;
        int                     hit_way;
        int                     vic;
        logic                   miss;
        logic                   wb;
        int                     cycles;
        int                     rd_seen;
        int                     wr_seen;
        logic                   done;

        a.raw = addr;
        idx = a.f.index;
        hit_way = -1;
        vic = 0;
        wb = 1'b0;
        wb_a.raw = '0;
        wb_line = '0;
        for (int w = 0; w < 2; w++)
            if (m_valid[idx][w] && m_tag[idx][w] == a.f.tag)
                hit_way = w;
        miss = (hit_way < 0);
        if (miss) begin
            if (!m_valid[idx][0])
                vic = 0;
            else if (!m_valid[idx][1])
                vic = 1;
            else
                vic = m_lru[idx] ? 0 : 1;
            wb = m_valid[idx][vic] && m_dirty[idx][vic];
            wb_a.raw = {m_tag[idx][vic], idx, 4'h0};
            for (int i = 0; i < `DC_WORDS; i++)
                wb_line[i] = arch_word(wb_a.raw + 32'(4 * i));
        end
        line_a.raw = {addr[31:4], 4'h0};
        exp_rd = arch_word(addr);

        r.op = op;
        r.addr = a;
        r.wdata = wdata;
        @(posedge clk);
        #1;
        valid = 1'b1;
        req = r;
        @(negedge clk);
        while (!addr_ok)
            @(negedge clk);
        @(posedge clk);     // accept edge
        #1;
        valid = 1'b0;
        req = ~r;   // the cache must hold its copy

        cycles = 0;
        rd_seen = 0;
        wr_seen = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (addr_ok)
                protocol_error("addr_ok high while a request is in flight");
            if (rd_req && !miss)
                protocol_error("rd_req raised for a request the model calls a hit");
            if (rd_req && rd_rdy) begin
                check_addr("rd_addr", line_a, rd_addr);
                rd_seen++;
            end
            if (wr_req && !wb)
                protocol_error("wr_req raised although the victim line is clean");
            if (wr_req && wr_rdy) begin
                check_addr("wr.addr", wb_a, wr.addr);
                check_line("wr.data", wb_line, wr.data);
                wr_seen++;
            end
            if (data_ok) begin
                done = 1'b1;
                if (op)
                    arch[addr] = wdata;
                else
                    check_word("rdata", exp_rd, rdata);
            end
        end

        if (!miss && cycles != 1)
            protocol_error($sformatf("hit took %0d cycles to data_ok instead of 1", cycles));
        if (rd_seen != (miss ? 1 : 0))
            protocol_error($sformatf("saw %0d refill reads for one request", rd_seen));
        if (wr_seen != (wb ? 1 : 0))
            protocol_error($sformatf("saw %0d write-backs for one request", wr_seen));

        if (miss) begin
            m_valid[idx][vic] = 1'b1;
            m_tag[idx][vic] = a.f.tag;
            m_dirty[idx][vic] = op;
            m_lru[idx] = vic[0];
        end else begin
            m_lru[idx] = hit_way[0];
            if (op)
                m_dirty[idx][hit_way] = 1'b1;
        end
    endtask

    // four tags over four sets
    task automatic random_requests(input int n, input logic allow_store);
        logic       op;
        logic [1:0] t;
        logic [1:0] s;
        logic [1:0] w;
        for (int k = 0; k < n; k++) begin
            op = allow_store & rand_bit();
            t = 2'(rand_bits(2));
            s = 2'(rand_bits(2));
            w = 2'(rand_bits(2));
            run_request(op, mk_addr(t, {s, 6'h2d}, w), rand_bits(32));
        end
    endtask

    // memory side with ready levels in random stretches
    always @(posedge clk) begin
        #1;
        if (rd_stretch == 0) begin
            rd_rdy = rand_bit();
            rd_stretch = int'(rand_bits(3));
        end else begin
            rd_stretch--;
        end
        if (wr_stretch == 0) begin
            wr_rdy = rand_bit();
            wr_stretch = int'(rand_bits(3));
        end else begin
            wr_stretch--;
        end
        ret_valid = 1'b0;
        if (ret_wait > 0) begin
            ret_wait--;
            if (ret_wait == 0) begin
                ret_valid = 1'b1;
                for (int i = 0; i < `DC_WORDS; i++)
                    ret_data[i] = mem_word(ret_addr + 32'(4 * i));
            end
        end
    end

    always @(negedge clk) begin
        if (rd_req && rd_rdy) begin
            ret_addr = rd_addr;
            ret_wait = 1 + int'(rand_bits(2));
            rd_count++;
        end
        if (wr_req && wr_rdy) begin
            for (int i = 0; i < `DC_WORDS; i++)
                mem[wr.addr + 32'(4 * i)] = wr.data[i];
            wr_count++;
        end
        if (valid && addr_ok)
            accept_count++;
        if (data_ok)
            done_count++;
    end

    initial begin
        #((N_REQ * 40 + 2) * CLK_NS);
        $display("run timed out before all %0d requests completed", N_REQ);
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        $display("test failed");
        $finish;
    end

    initial begin
        clk = 1'b0;
        resetn = 1'b1;
        valid = 1'b0;
        req = '0;
        rd_rdy = 1'b0;
        wr_rdy = 1'b0;
        ret_valid = 1'b0;
        ret_data = '0;
        lfsr_state = 32'h8e6ccf5f;
        value_errors = 0;
        protocol_errors = 0;
        accept_count = 0;
        done_count = 0;
        rd_count = 0;
        wr_count = 0;
        rd_stretch = 0;
        wr_stretch = 0;
        ret_wait = 0;
        ret_addr = '0;
        for (int s = 0; s < `DC_SETS; s++) begin
            m_lru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                m_valid[s][w] = 1'b0;
                m_tag[s][w] = '0;
                m_dirty[s][w] = 1'b0;
            end
        end

        repeat (2) @(posedge clk);
        #1;
        resetn = 1'b0;
        @(negedge clk);
        if (!addr_ok || data_ok || rd_req || wr_req)
            protocol_error("cache is not idle after reset");

        for (int s = 0; s < N_FIRST; s++)
            run_request(1'b0, mk_addr(2'd0, {2'(s), 6'h2d}, 2'(rand_bits(2))), '0);
        if (rd_count != N_FIRST)
            protocol_error("first loads did not cause one refill per set");

        random_requests(N_LOADS, 1'b0);
        if (wr_count != 0)
            protocol_error("write-back seen during the load-only phase");

        // A B A C B C where C pushes out B and then B pushes out A
        rd_mark = rd_count;
        run_request(1'b0, mk_addr(2'd0, 8'h17, 2'd1), '0);
        run_request(1'b0, mk_addr(2'd1, 8'h17, 2'd2), '0);
        run_request(1'b0, mk_addr(2'd0, 8'h17, 2'd3), '0);
        run_request(1'b0, mk_addr(2'd2, 8'h17, 2'd0), '0);
        run_request(1'b0, mk_addr(2'd1, 8'h17, 2'd0), '0);
        run_request(1'b0, mk_addr(2'd2, 8'h17, 2'd1), '0);
        if (rd_count - rd_mark != 4)
            protocol_error("three tags in one set did not refill four times");

        random_requests(N_MIXED, 1'b1);

        @(negedge clk);
        if (accept_count != N_REQ || done_count != accept_count)
            protocol_error($sformatf("%0d accepted, %0d completed, %0d issued",
                                     accept_count, done_count, N_REQ));

        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule
